/* include/rammodel_config.svh */
`ifndef RAMMODEL_CONFIG_SVH
`define RAMMODEL_CONFIG_SVH

`define RAMMODEL_ADDR_WIDTH 32
`define RAMMODEL_DATA_WIDTH 32
`define RAMMODEL_ID_WIDTH   4
// Beats per burst are len + 1
`define RAMMODEL_LEN_WIDTH  8

`define RAMMODEL_A_DEPTH    8
`define RAMMODEL_W_DEPTH    256
`define RAMMODEL_R_DEPTH    256
`define RAMMODEL_B_DEPTH    2

`endif

/* hw/frontend_pkg.sv */
`include "rammodel_config.svh"

package frontend_pkg;

    typedef logic [`RAMMODEL_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`RAMMODEL_DATA_WIDTH-1:0] data_t;
    typedef logic [`RAMMODEL_ID_WIDTH-1:0]   id_t;
    typedef logic [`RAMMODEL_LEN_WIDTH-1:0]  len_t;

    // One request per burst
    typedef struct packed {
        logic  write;
        addr_t addr;
        id_t   id;
        len_t  len;
    } fe_a_t;

    typedef struct packed {
        data_t data;
        logic  last;
    } fe_w_t;

    typedef struct packed {
        id_t id;
    } fe_b_t;

    typedef struct packed {
        id_t   id;
        data_t data;
        logic  last;
    } fe_r_t;

endpackage

/* hw/host_axi_pkg.sv */
package host_axi_pkg;

    import frontend_pkg::*;

    // Shared by AW and AR
    typedef struct packed {
        id_t   id;
        addr_t addr;
        len_t  len;
    } axi_addr_t;

    typedef struct packed {
        data_t data;
        logic  last;
    } axi_w_t;

    typedef struct packed {
        id_t id;
    } axi_b_t;

    typedef struct packed {
        id_t   id;
        data_t data;
        logic  last;
    } axi_r_t;

endpackage

/* hw/sync_fifo.sv */
module sync_fifo #(
    parameter int WIDTH     = 32,
    parameter int DEPTH     = 8,
    parameter bit USE_BURST = 1'b0
) (
    input  logic                     host_clk,
    input  logic                     host_rst,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  logic [WIDTH-1:0]         in_data,
    input  logic                     in_last,
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic [WIDTH-1:0]         out_data,
    output logic                     out_last,
    output logic                     empty,
    output logic [$clog2(DEPTH):0]   burst_count
);

    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW:0]      wr_ptr;
    logic [AW:0]      rd_ptr;
    logic [AW:0]      count;
    logic             wr_fire;
    logic             rd_fire;

    // Extra pointer bit tells full from empty
    assign count     = wr_ptr - rd_ptr;
    assign empty     = count == 0;
    assign in_ready  = count != DEPTH;
    assign out_valid = !empty;
    assign out_data  = mem[rd_ptr[AW-1:0]];
    assign wr_fire   = in_valid && in_ready;
    assign rd_fire   = out_valid && out_ready;

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_fire)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_fire)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge host_clk) begin
        if (wr_fire)
            mem[wr_ptr[AW-1:0]] <= in_data;
    end

    // A full FIFO that is not read stays full, so no write slipped in
    a_no_overflow: assert property (@(posedge host_clk) disable iff (host_rst)
        (count == DEPTH && !rd_fire) |=> count == DEPTH);

    generate
        if (USE_BURST) begin : g_burst
            logic        last_mem [DEPTH];
            logic [AW:0] burst_cnt;
            logic        wr_last;
            logic        rd_last;

            assign wr_last     = wr_fire && in_last;
            assign rd_last     = rd_fire && out_last;
            assign out_last    = last_mem[rd_ptr[AW-1:0]];
            assign burst_count = burst_cnt;

            always_ff @(posedge host_clk) begin
                if (wr_fire)
                    last_mem[wr_ptr[AW-1:0]] <= in_last;
            end

            // Complete bursts currently held
            always_ff @(posedge host_clk) begin
                if (host_rst)
                    burst_cnt <= '0;
                else if (wr_last && !rd_last)
                    burst_cnt <= burst_cnt + 1'b1;
                else if (rd_last && !wr_last)
                    burst_cnt <= burst_cnt - 1'b1;
            end

            a_burst_no_underflow: assert property (@(posedge host_clk) disable iff (host_rst)
                rd_last |-> burst_cnt != 0);
        end else begin : g_no_burst
            assign out_last    = 1'b0;
            assign burst_count = '0;
        end
    endgenerate

endmodule

/* hw/request_queue.sv */
`include "rammodel_config.svh"

module request_queue (
    input  logic                 host_clk,
    input  logic                 host_rst,
    input  logic                 a_valid,
    output logic                 a_ready,
    input  frontend_pkg::fe_a_t  a,
    input  logic                 w_valid,
    output logic                 w_ready,
    input  frontend_pkg::fe_w_t  w,
    output logic                 head_a_valid,
    input  logic                 head_a_ready,
    output frontend_pkg::fe_a_t  head_a,
    output logic                 head_w_valid,
    input  logic                 head_w_ready,
    output frontend_pkg::fe_w_t  head_w,
    output logic                 burst_ready
);

    import frontend_pkg::*;

    data_t                              w_head_data;
    logic                               w_head_last;
    logic [$clog2(`RAMMODEL_W_DEPTH):0] w_burst_count;

    sync_fifo #(
        .WIDTH       ($bits(fe_a_t)),
        .DEPTH       (`RAMMODEL_A_DEPTH),
        .USE_BURST   (1'b0)
    ) i_a_fifo (
        .host_clk    (host_clk),
        .host_rst    (host_rst),
        .in_valid    (a_valid),
        .in_ready    (a_ready),
        .in_data     (a),
        .in_last     (1'b0),
        .out_valid   (head_a_valid),
        .out_ready   (head_a_ready),
        .out_data    (head_a),
        .out_last    (),
        .empty       (),
        .burst_count ()
    );

    sync_fifo #(
        .WIDTH       ($bits(data_t)),
        .DEPTH       (`RAMMODEL_W_DEPTH),
        .USE_BURST   (1'b1)
    ) i_w_fifo (
        .host_clk    (host_clk),
        .host_rst    (host_rst),
        .in_valid    (w_valid),
        .in_ready    (w_ready),
        .in_data     (w.data),
        .in_last     (w.last),
        .out_valid   (head_w_valid),
        .out_ready   (head_w_ready),
        .out_data    (w_head_data),
        .out_last    (w_head_last),
        .empty       (),
        .burst_count (w_burst_count)
    );

    assign head_w = '{data: w_head_data, last: w_head_last};

    // Writes wait until their whole burst is stored
    assign burst_ready = w_burst_count != 0;

endmodule

/* hw/response_buffer.sv */
`include "rammodel_config.svh"

module response_buffer (
    input  logic                  host_clk,
    input  logic                  host_rst,
    input  logic                  b_valid,
    output logic                  b_ready,
    input  host_axi_pkg::axi_b_t  b,
    input  logic                  r_valid,
    output logic                  r_ready,
    input  host_axi_pkg::axi_r_t  r,
    input  logic                  breq_valid,
    input  logic                  rreq_valid,
    output logic                  fe_b_valid,
    input  logic                  fe_b_ready,
    output frontend_pkg::fe_b_t   fe_b,
    output logic                  fe_r_valid,
    input  logic                  fe_r_ready,
    output frontend_pkg::fe_r_t   fe_r,
    output logic                  idle
);

    import frontend_pkg::*;

    localparam int R_W = $bits(id_t) + $bits(data_t);

    logic           b_head_valid;
    logic           b_empty;
    logic           r_head_valid;
    logic [R_W-1:0] r_head;
    logic           r_head_last;
    logic           r_empty;

    sync_fifo #(
        .WIDTH       ($bits(fe_b_t)),
        .DEPTH       (`RAMMODEL_B_DEPTH),
        .USE_BURST   (1'b0)
    ) i_b_fifo (
        .host_clk    (host_clk),
        .host_rst    (host_rst),
        .in_valid    (b_valid),
        .in_ready    (b_ready),
        .in_data     (b.id),
        .in_last     (1'b0),
        .out_valid   (b_head_valid),
        .out_ready   (fe_b_ready && breq_valid),
        .out_data    (fe_b),
        .out_last    (),
        .empty       (b_empty),
        .burst_count ()
    );

    sync_fifo #(
        .WIDTH       (R_W),
        .DEPTH       (`RAMMODEL_R_DEPTH),
        .USE_BURST   (1'b1)
    ) i_r_fifo (
        .host_clk    (host_clk),
        .host_rst    (host_rst),
        .in_valid    (r_valid),
        .in_ready    (r_ready),
        .in_data     ({r.id, r.data}),
        .in_last     (r.last),
        .out_valid   (r_head_valid),
        .out_ready   (fe_r_ready && rreq_valid),
        .out_data    (r_head),
        .out_last    (r_head_last),
        .empty       (r_empty),
        .burst_count ()
    );

    // Released only while the frontend asks for it
    assign fe_b_valid = b_head_valid && breq_valid;
    assign fe_r_valid = r_head_valid && rreq_valid;

    assign fe_r = '{
        id:   r_head[R_W-1 -: $bits(id_t)],
        data: r_head[$bits(data_t)-1:0],
        last: r_head_last
    };

    assign idle = b_empty && r_empty;

    // A held-back response waits unchanged at the head
    a_b_held: assert property (@(posedge host_clk) disable iff (host_rst)
        (b_head_valid && !breq_valid) |=> b_head_valid && $stable(fe_b));
    a_r_held: assert property (@(posedge host_clk) disable iff (host_rst)
        (r_head_valid && !rreq_valid) |=> r_head_valid && $stable(fe_r));

endmodule

/* hw/transfer_scheduler.sv */
module transfer_scheduler (
    input  logic                     host_clk,
    input  logic                     host_rst,
    input  logic                     head_a_valid,
    output logic                     head_a_ready,
    input  frontend_pkg::fe_a_t      head_a,
    input  logic                     head_w_valid,
    output logic                     head_w_ready,
    input  frontend_pkg::fe_w_t      head_w,
    input  logic                     burst_ready,
    input  logic                     resp_idle,
    output logic                     aw_valid,
    input  logic                     aw_ready,
    output logic                     ar_valid,
    input  logic                     ar_ready,
    output host_axi_pkg::axi_addr_t  addr,
    output logic                     w_valid,
    input  logic                     w_ready,
    output host_axi_pkg::axi_w_t     w,
    input  logic                     b_done,
    input  logic                     r_last_done
);

    typedef enum logic [2:0] {
        IDLE,
        DO_A,
        DO_W,
        DO_B,
        DO_R
    } state_t;

    state_t state;
    state_t state_next;
    logic   ok_to_issue;
    logic   a_fire;
    logic   w_fire;

    // Reads go at once, writes only with all beats stored
    assign ok_to_issue = head_a_valid && (!head_a.write || burst_ready) && resp_idle;

    assign aw_valid     = state == DO_A && head_a.write;
    assign ar_valid     = state == DO_A && !head_a.write;
    assign a_fire       = (aw_valid && aw_ready) || (ar_valid && ar_ready);
    assign head_a_ready = a_fire;
    assign addr         = '{id: head_a.id, addr: head_a.addr, len: head_a.len};

    assign w_valid      = state == DO_W && head_w_valid;
    assign head_w_ready = state == DO_W && w_ready;
    assign w_fire       = w_valid && w_ready;
    assign w            = '{data: head_w.data, last: head_w.last};

    always_ff @(posedge host_clk) begin
        if (host_rst)
            state <= IDLE;
        else
            state <= state_next;
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (ok_to_issue)
                    state_next = DO_A;
            end
            DO_A: begin
                if (a_fire)
                    state_next = head_a.write ? DO_W : DO_R;
            end
            DO_W: begin
                if (w_fire && head_w.last)
                    state_next = DO_B;
            end
            DO_B: begin
                if (b_done)
                    state_next = IDLE;
            end
            DO_R: begin
                if (r_last_done)
                    state_next = IDLE;
            end
            default: state_next = IDLE;
        endcase
    end

    // An address goes out only once all earlier responses have left the buffer
    a_issue_when_idle: assert property (@(posedge host_clk) disable iff (host_rst)
        (aw_valid || ar_valid) |-> resp_idle && !(aw_valid && ar_valid));

    a_addr_held: assert property (@(posedge host_clk) disable iff (host_rst)
        (aw_valid && !aw_ready) |=> aw_valid && $stable(addr));

endmodule

/* hw/rammodel_backend.sv */
module rammodel_backend (
    input  logic                     host_clk,
    input  logic                     host_rst,
    input  logic                     fe_a_valid,
    output logic                     fe_a_ready,
    input  frontend_pkg::fe_a_t      fe_a,
    input  logic                     fe_w_valid,
    output logic                     fe_w_ready,
    input  frontend_pkg::fe_w_t      fe_w,
    output logic                     fe_b_valid,
    input  logic                     fe_b_ready,
    output frontend_pkg::fe_b_t      fe_b,
    output logic                     fe_r_valid,
    input  logic                     fe_r_ready,
    output frontend_pkg::fe_r_t      fe_r,
    input  logic                     breq_valid,
    input  logic                     rreq_valid,
    output logic                     host_aw_valid,
    input  logic                     host_aw_ready,
    output host_axi_pkg::axi_addr_t  host_aw,
    output logic                     host_ar_valid,
    input  logic                     host_ar_ready,
    output host_axi_pkg::axi_addr_t  host_ar,
    output logic                     host_w_valid,
    input  logic                     host_w_ready,
    output host_axi_pkg::axi_w_t     host_w,
    input  logic                     host_b_valid,
    output logic                     host_b_ready,
    input  host_axi_pkg::axi_b_t     host_b,
    input  logic                     host_r_valid,
    output logic                     host_r_ready,
    input  host_axi_pkg::axi_r_t     host_r
);

    import frontend_pkg::*;
    import host_axi_pkg::*;

    fe_a_t     head_a;
    fe_w_t     head_w;
    axi_addr_t sched_addr;
    logic      head_a_valid;
    logic      head_a_ready;
    logic      head_w_valid;
    logic      head_w_ready;
    logic      burst_ready;
    logic      resp_idle;
    logic      b_done;
    logic      r_last_done;

    // Host handshakes that close a transaction
    assign b_done      = host_b_valid && host_b_ready;
    assign r_last_done = host_r_valid && host_r_ready && host_r.last;

    assign host_aw = sched_addr;
    assign host_ar = sched_addr;

    request_queue i_request_queue (
        .host_clk     (host_clk),
        .host_rst     (host_rst),
        .a_valid      (fe_a_valid),
        .a_ready      (fe_a_ready),
        .a            (fe_a),
        .w_valid      (fe_w_valid),
        .w_ready      (fe_w_ready),
        .w            (fe_w),
        .head_a_valid (head_a_valid),
        .head_a_ready (head_a_ready),
        .head_a       (head_a),
        .head_w_valid (head_w_valid),
        .head_w_ready (head_w_ready),
        .head_w       (head_w),
        .burst_ready  (burst_ready)
    );

    response_buffer i_response_buffer (
        .host_clk     (host_clk),
        .host_rst     (host_rst),
        .b_valid      (host_b_valid),
        .b_ready      (host_b_ready),
        .b            (host_b),
        .r_valid      (host_r_valid),
        .r_ready      (host_r_ready),
        .r            (host_r),
        .breq_valid   (breq_valid),
        .rreq_valid   (rreq_valid),
        .fe_b_valid   (fe_b_valid),
        .fe_b_ready   (fe_b_ready),
        .fe_b         (fe_b),
        .fe_r_valid   (fe_r_valid),
        .fe_r_ready   (fe_r_ready),
        .fe_r         (fe_r),
        .idle         (resp_idle)
    );

    transfer_scheduler i_transfer_scheduler (
        .host_clk     (host_clk),
        .host_rst     (host_rst),
        .head_a_valid (head_a_valid),
        .head_a_ready (head_a_ready),
        .head_a       (head_a),
        .head_w_valid (head_w_valid),
        .head_w_ready (head_w_ready),
        .head_w       (head_w),
        .burst_ready  (burst_ready),
        .resp_idle    (resp_idle),
        .aw_valid     (host_aw_valid),
        .aw_ready     (host_aw_ready),
        .ar_valid     (host_ar_valid),
        .ar_ready     (host_ar_ready),
        .addr         (sched_addr),
        .w_valid      (host_w_valid),
        .w_ready      (host_w_ready),
        .w            (host_w),
        .b_done       (b_done),
        .r_last_done  (r_last_done)
    );

endmodule

/* verification/host_memory_model.sv */
module host_memory_model (
    input  logic                     host_clk,
    input  logic                     host_rst,
    input  logic                     aw_valid,
    output logic                     aw_ready,
    input  host_axi_pkg::axi_addr_t  aw,
    input  logic                     ar_valid,
    output logic                     ar_ready,
    input  host_axi_pkg::axi_addr_t  ar,
    input  logic                     w_valid,
    output logic                     w_ready,
    input  host_axi_pkg::axi_w_t     w,
    output logic                     b_valid,
    input  logic                     b_ready,
    output host_axi_pkg::axi_b_t     b,
    output logic                     r_valid,
    input  logic                     r_ready,
    output host_axi_pkg::axi_r_t     r
);

    timeunit 1ns;
    timeprecision 1ps;

    import frontend_pkg::*;
    import host_axi_pkg::*;

    data_t     mem [addr_t];
    axi_addr_t cur;
    int        beat;
    int        reads_left;
    logic      b_pending;
    logic      b_taken;
    logic      r_taken;

    // Unwritten words read back as a pattern of their address
    function automatic data_t read_word(input addr_t a);
        if (mem.exists(a))
            return mem[a];
        return a ^ 32'h5a5a_5a5a;
    endfunction

    initial begin
        aw_ready   = 1'b0;
        ar_ready   = 1'b0;
        w_ready    = 1'b0;
        b_valid    = 1'b0;
        r_valid    = 1'b0;
        b          = '0;
        r          = '0;
        cur        = '0;
        beat       = 0;
        reads_left = 0;
        b_pending  = 1'b0;
    end

    always @(posedge host_clk) begin
        b_taken = b_valid && b_ready;
        r_taken = r_valid && r_ready;
        if (aw_valid && aw_ready) begin
            cur  = aw;
            beat = 0;
        end
        if (ar_valid && ar_ready) begin
            cur        = ar;
            beat       = 0;
            reads_left = int'(ar.len) + 1;
        end
        if (w_valid && w_ready) begin
            mem[addr_t'(cur.addr + 4 * beat)] = w.data;
            beat++;
            if (w.last)
                b_pending = 1'b1;
        end
        #1;
        if (host_rst) begin
            aw_ready   = 1'b0;
            ar_ready   = 1'b0;
            w_ready    = 1'b0;
            b_valid    = 1'b0;
            r_valid    = 1'b0;
            b_pending  = 1'b0;
            reads_left = 0;
        end else begin
            // Random ready gaps stall the scheduler
            aw_ready = $urandom_range(3) == 0;
            ar_ready = $urandom_range(3) == 0;
            w_ready  = $urandom_range(2) != 0;
            if (b_taken)
                b_valid = 1'b0;
            if (b_pending && !b_valid && $urandom_range(3) == 0) begin
                b_valid   = 1'b1;
                b         = '{id: cur.id};
                b_pending = 1'b0;
            end
            if (r_taken)
                r_valid = 1'b0;
            if (reads_left > 0 && !r_valid && $urandom_range(2) != 0) begin
                r_valid = 1'b1;
                r = '{
                    id:   cur.id,
                    data: read_word(addr_t'(cur.addr + 4 * beat)),
                    last: reads_left == 1
                };
                reads_left--;
                beat++;
            end
        end
    end

endmodule

/* verification/rammodel_backend_tb.sv */
module rammodel_backend_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import frontend_pkg::*;
    import host_axi_pkg::*;

    typedef struct packed {
        logic  write;
        addr_t addr;
        id_t   id;
        len_t  len;
        data_t seed;
    } op_t;

    localparam int NUM_OPS     = 11;
    localparam int CYCLE_LIMIT = 300 * NUM_OPS + 100;

    // Reads of 0x400 before its write see the fill pattern
    op_t ops [NUM_OPS] = '{
        '{1'b1, 32'h0000_0100, 4'h1, 8'd3,  32'h1000_0000},
        '{1'b0, 32'h0000_0100, 4'h2, 8'd3,  32'h0},
        '{1'b1, 32'h0000_0200, 4'h3, 8'd0,  32'h2000_0000},
        '{1'b1, 32'h0000_0300, 4'h4, 8'd7,  32'h3000_0000},
        '{1'b0, 32'h0000_0200, 4'h5, 8'd0,  32'h0},
        '{1'b0, 32'h0000_0300, 4'h6, 8'd7,  32'h0},
        '{1'b1, 32'h0000_0104, 4'h7, 8'd1,  32'h4000_0000},
        '{1'b0, 32'h0000_0100, 4'h8, 8'd3,  32'h0},
        '{1'b0, 32'h0000_0400, 4'h9, 8'd2,  32'h0},
        '{1'b1, 32'h0000_0400, 4'ha, 8'd15, 32'h5000_0000},
        '{1'b0, 32'h0000_0400, 4'hb, 8'd15, 32'h0}
    };

    logic      host_clk;
    logic      host_rst;
    logic      fe_a_valid;
    logic      fe_a_ready;
    fe_a_t     fe_a;
    logic      fe_w_valid;
    logic      fe_w_ready;
    fe_w_t     fe_w;
    logic      fe_b_valid;
    logic      fe_b_ready;
    fe_b_t     fe_b;
    logic      fe_r_valid;
    logic      fe_r_ready;
    fe_r_t     fe_r;
    logic      breq_valid;
    logic      rreq_valid;
    logic      host_aw_valid;
    logic      host_aw_ready;
    axi_addr_t host_aw;
    logic      host_ar_valid;
    logic      host_ar_ready;
    axi_addr_t host_ar;
    logic      host_w_valid;
    logic      host_w_ready;
    axi_w_t    host_w;
    logic      host_b_valid;
    logic      host_b_ready;
    axi_b_t    host_b;
    logic      host_r_valid;
    logic      host_r_ready;
    axi_r_t    host_r;

    data_t     sb [addr_t];
    int        cycle_count = 0;
    int        open_txns = 0;
    int        w_bursts_in = 0;
    int        aw_count = 0;
    int        issue_idx = 0;
    int        host_b_count = 0;
    int        fe_b_count = 0;
    int        fe_r_bursts = 0;

    rammodel_backend i_rammodel_backend (.*);

    host_memory_model i_host_memory_model (
        .host_clk (host_clk),
        .host_rst (host_rst),
        .aw_valid (host_aw_valid),
        .aw_ready (host_aw_ready),
        .aw       (host_aw),
        .ar_valid (host_ar_valid),
        .ar_ready (host_ar_ready),
        .ar       (host_ar),
        .w_valid  (host_w_valid),
        .w_ready  (host_w_ready),
        .w        (host_w),
        .b_valid  (host_b_valid),
        .b_ready  (host_b_ready),
        .b        (host_b),
        .r_valid  (host_r_valid),
        .r_ready  (host_r_ready),
        .r        (host_r)
    );

    always #2 host_clk = ~host_clk;

    task automatic report_error(input string msg);
        $display("Checks failed");
        $display("Error at %0t ns: %s", $time, msg);
        $fatal(1);
    endtask

    function automatic data_t beat_data(input data_t seed, input int beat);
        return seed ^ (beat * 32'h0101_0101) ^ beat;
    endfunction

    function automatic data_t expected_word(input addr_t a);
        if (sb.exists(a))
            return sb[a];
        return a ^ 32'h5a5a_5a5a;
    endfunction

    // Host id carries the frontend id, address and length pass through
    function automatic axi_addr_t host_addr_of(input op_t op);
        return '{id: op.id, addr: op.addr, len: op.len};
    endfunction

    function automatic int count_ops(input logic write);
        int n;
        n = 0;
        for (int i = 0; i < NUM_OPS; i++)
            if (ops[i].write == write)
                n++;
        return n;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge host_clk);
            #1;
        end
    endtask

    task automatic check_quiet_outputs(input string when);
        assert (!host_aw_valid && !host_ar_valid && !host_w_valid && !fe_b_valid && !fe_r_valid)
        else report_error({"valid output high ", when});
    endtask

    task automatic send_request(input op_t op);
        fe_a_valid = 1'b1;
        fe_a = '{write: op.write, addr: op.addr, id: op.id, len: op.len};
        do @(posedge host_clk); while (!fe_a_ready);
        #1;
        fe_a_valid = 1'b0;
    endtask

    task automatic send_beat(input data_t data, input logic last);
        idle_cycles($urandom_range(2));
        fe_w_valid = 1'b1;
        fe_w = '{data: data, last: last};
        do @(posedge host_clk); while (!fe_w_ready);
        #1;
        fe_w_valid = 1'b0;
    endtask

    task automatic drive_requests();
        for (int i = 0; i < NUM_OPS; i++) begin
            send_request(ops[i]);
            if (ops[i].write)
                for (int j = 0; j <= int'(ops[i].len); j++)
                    send_beat(beat_data(ops[i].seed, j), j == int'(ops[i].len));
        end
    endtask

    task automatic take_b(input op_t op);
        breq_valid = 1'b1;
        fe_b_ready = 1'b1;
        do @(posedge host_clk); while (!fe_b_valid);
        assert (fe_b.id == op.id)
        else report_error($sformatf("bid %0h, expected %0h", fe_b.id, op.id));
        #1;
        breq_valid = 1'b0;
        fe_b_ready = 1'b0;
        for (int j = 0; j <= int'(op.len); j++)
            sb[addr_t'(op.addr + 4 * j)] = beat_data(op.seed, j);
    endtask

    task automatic take_r(input op_t op);
        data_t exp;
        rreq_valid = 1'b1;
        fe_r_ready = 1'b1;
        for (int j = 0; j <= int'(op.len); j++) begin
            do @(posedge host_clk); while (!fe_r_valid);
            exp = expected_word(addr_t'(op.addr + 4 * j));
            assert (fe_r.data == exp)
            else report_error($sformatf("rdata %h, expected %h", fe_r.data, exp));
            assert (fe_r.id == op.id)
            else report_error($sformatf("rid %0h, expected %0h", fe_r.id, op.id));
            assert (fe_r.last == (j == int'(op.len)))
            else report_error($sformatf("rlast %b on beat %0d", fe_r.last, j));
        end
        #1;
        rreq_valid = 1'b0;
        fe_r_ready = 1'b0;
    endtask

    // Responses are taken in table order after a random hold-off
    task automatic collect_responses();
        for (int i = 0; i < NUM_OPS; i++) begin
            idle_cycles($urandom_range(6));
            if (ops[i].write)
                take_b(ops[i]);
            else
                take_r(ops[i]);
        end
    endtask

    always @(posedge host_clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Checks failed");
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $fatal(1);
        end
    end

    // Protocol monitor, checks before counting this edge
    always @(posedge host_clk) begin
        if (!host_rst) begin
            assert (!(host_aw_valid && host_ar_valid))
            else report_error("aw_valid and ar_valid high together");
            if (host_aw_valid || host_ar_valid)
                assert (open_txns == 0)
                else report_error("address issued while a response is still pending");
            if (host_aw_valid)
                assert (w_bursts_in > aw_count)
                else report_error("aw_valid before all write beats were delivered");
            if (host_aw_valid && host_aw_ready)
                assert (issue_idx < NUM_OPS && ops[issue_idx].write
                        && host_aw == host_addr_of(ops[issue_idx]))
                else report_error($sformatf("host aw %h for table entry %0d",
                                            host_aw, issue_idx));
            if (host_ar_valid && host_ar_ready)
                assert (issue_idx < NUM_OPS && !ops[issue_idx].write
                        && host_ar == host_addr_of(ops[issue_idx]))
                else report_error($sformatf("host ar %h for table entry %0d",
                                            host_ar, issue_idx));
            assert (breq_valid || !fe_b_valid)
            else report_error("fe_b_valid high while breq_valid is low");
            assert (rreq_valid || !fe_r_valid)
            else report_error("fe_r_valid high while rreq_valid is low");
            if (fe_w_valid && fe_w_ready && fe_w.last)
                w_bursts_in++;
            if (host_aw_valid && host_aw_ready) begin
                aw_count++;
                open_txns++;
                issue_idx++;
            end
            if (host_ar_valid && host_ar_ready) begin
                open_txns++;
                issue_idx++;
            end
            if (host_b_valid && host_b_ready)
                host_b_count++;
            if (fe_b_valid && fe_b_ready) begin
                fe_b_count++;
                open_txns--;
            end
            if (fe_r_valid && fe_r_ready && fe_r.last) begin
                fe_r_bursts++;
                open_txns--;
            end
        end
    end

    initial begin
        void'($urandom(32'h4ae300d2));
        host_clk   = 1'b0;
        host_rst   = 1'b1;
        fe_a_valid = 1'b0;
        fe_a       = '0;
        fe_w_valid = 1'b0;
        fe_w       = '0;
        fe_b_ready = 1'b0;
        fe_r_ready = 1'b0;
        breq_valid = 1'b0;
        rreq_valid = 1'b0;
        @(posedge host_clk);
        repeat (4) begin
            @(posedge host_clk);
            check_quiet_outputs("during reset");
        end
        #1;
        host_rst = 1'b0;
        @(posedge host_clk);
        check_quiet_outputs("right after reset");
        #1;
        fork
            drive_requests();
            collect_responses();
        join
        assert (host_b_count == count_ops(1'b1) && fe_b_count == count_ops(1'b1))
        else report_error($sformatf("%0d host and %0d frontend B responses", host_b_count,
                                    fe_b_count));
        assert (fe_r_bursts == count_ops(1'b0))
        else report_error($sformatf("%0d read bursts returned", fe_r_bursts));
        $display("All checks passed");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+include
hw/frontend_pkg.sv
hw/host_axi_pkg.sv
hw/sync_fifo.sv
hw/request_queue.sv
hw/response_buffer.sv
hw/transfer_scheduler.sv
hw/rammodel_backend.sv
verification/host_memory_model.sv
verification/rammodel_backend_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rammodel_backend_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All checks passed

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) include/rammodel_config.svh

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
